//--- tb.f
hw/periphPkg.sv
hw/machineTimer.sv
hw/spiMaster.sv
hw/sysCtrl.sv
hw/ioBusDecode.sv
hw/ioSubsystem.sv
bench/ioSubsystem_chk.sv
bench/ioSubsystem_tb.sv

//--- Bender.yml
package:
  name: io_subsystem

sources:
  - files:
      - hw/periphPkg.sv
      - hw/machineTimer.sv
      - hw/spiMaster.sv
      - hw/sysCtrl.sv
      - hw/ioBusDecode.sv
      - hw/ioSubsystem.sv
  - target: simulation
    files:
      - bench/ioSubsystem_chk.sv
      - bench/ioSubsystem_tb.sv

//--- bench/ioSubsystem_tb.sv
`timescale 1ns/1ps

module ioSubsystem_tb;
    import periphPkg::*;

    logic        clk;
    logic        rst;
    busReq_t     req;
    busRsp_t     rsp;
    logic        spiCs;
    logic        spiSck;
    logic        spiMosi;
    logic [63:0] mtime;
    logic        timerIrq;
    logic        reboot;
    logic        powerOff;

    int          edgeCnt;
    int          errors;
    int          checks;
    logic [31:0] seed;
    logic [31:0] expData[$];
    logic [31:0] expAddr[$];
    logic [31:0] cmpExp;
    logic [31:0] cmpAddr;

    // Shadow state of the peripherals.
    logic [63:0] cmpModel;
    logic [63:0] mtimeBase;
    int          mtimeEdge;
    int          spiStart;
    int          spiLen;
    logic [31:0] spiWord;
    logic        rxRead;

    // MISO is looped back from MOSI.
    ioSubsystem UUT (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req),
        .rsp_o      (rsp),
        .spiMiso_i  (spiMosi),
        .spiCs_o    (spiCs),
        .spiSck_o   (spiSck),
        .spiMosi_o  (spiMosi),
        .mtime_o    (mtime),
        .timerIrq_o (timerIrq),
        .reboot_o   (reboot),
        .powerOff_o (powerOff)
    );

    bind ioSubsystem ioSubsystem_chk checks (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req_i),
        .rsp_i      (rsp_o),
        .spiCs_i    (spiCs_o),
        .spiSck_i   (spiSck_o),
        .reboot_i   (reboot_o),
        .powerOff_i (powerOff_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Counts the edges seen out of reset; the prescaler fires on every fifth.
    always @(posedge clk) begin
        if (rst) begin
            edgeCnt <= 0;
        end else begin
            edgeCnt <= edgeCnt + 1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic logic [31:0] applyMask(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] mask);
        logic [31:0] bm;
        bm = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old & ~bm) | (data & bm);
    endfunction

    // mtime as it stands after edge k.
    function automatic logic [63:0] mtimeAt(input int k);
        return mtimeBase + 64'(TimerStep) * 64'(k / TimerDivide - mtimeEdge / TimerDivide);
    endfunction

    function automatic logic spiBusyAt(input int e);
        return spiStart >= 0 && e >= spiStart && e <= spiStart + 2 * spiLen;
    endfunction

    // sck is high on the second cycle of every bit.
    function automatic logic spiSckAt(input int e);
        return spiBusyAt(e) && ((e - spiStart) % 2 == 1);
    endfunction

    function automatic logic rxValidAt(input int e);
        return spiStart >= 0 && e > spiStart + 2 * spiLen && !rxRead;
    endfunction

    // Expected read data for a request driven while edgeCnt equals e.
    function automatic logic [31:0] expectedRead(input logic [31:0] addr, input int e);
        logic [63:0] mt;
        logic [31:0] st;
        mt = mtimeAt(e);
        st = '0;
        st[SpiStatusBusyBit]    = spiBusyAt(e);
        st[SpiStatusRxValidBit] = rxValidAt(e);
        case (addr)
            MtimeAddr:             return mt[31:0];
            MtimeAddr + 32'd4:     return mt[63:32];
            MtimecmpAddr:          return cmpModel[31:0];
            MtimecmpAddr + 32'd4:  return cmpModel[63:32];
            SpiDataAddr:           return spiWord;
            SpiStatusAddr:         return st;
            default:               return 32'h0;
        endcase
    endfunction

    // A write driven while edgeCnt equals e lands at edge e+1.
    function automatic void modelWrite(input logic [31:0] addr, input logic [31:0] data,
                                       input logic [3:0] mask, input int e);
        logic [63:0] stepped;
        int          n;
        stepped = mtimeAt(e + 1);
        case (addr)
            MtimeAddr: begin
                mtimeBase = {stepped[63:32], applyMask(stepped[31:0], data, mask)};
                mtimeEdge = e + 1;
            end
            MtimeAddr + 32'd4: begin
                mtimeBase = {applyMask(stepped[63:32], data, mask), stepped[31:0]};
                mtimeEdge = e + 1;
            end
            MtimecmpAddr:         cmpModel[31:0]  = applyMask(cmpModel[31:0], data, mask);
            MtimecmpAddr + 32'd4: cmpModel[63:32] = applyMask(cmpModel[63:32], data, mask);
            SpiDataAddr: begin
                if (!spiBusyAt(e)) begin
                    n = (mask == 4'b0001) ? 8 : (mask == 4'b0011) ? 16 : 32;
                    spiStart = e + 1;
                    spiLen   = n;
                    spiWord  = (n == 32) ? data : data & ((32'h1 << n) - 1);
                    rxRead   = 1'b0;
                end
            end
            default: ;
        endcase
    endfunction

    task automatic finishRun();
        int total;
        total = errors + UUT.checks.failCount;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, UUT.checks.failCount);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        finishRun();
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
        modelWrite(addr, data, mask, edgeCnt);
        req       = '0;
        req.we    = 1'b1;
        req.addr  = addr[31:2];
        req.wmask = mask;
        req.wdata = data;
        @(posedge clk);
        #1;
        req = '0;
    endtask

    task automatic busRead(input logic [31:0] addr);
        expData.push_back(expectedRead(addr, edgeCnt));
        expAddr.push_back(addr);
        if (addr == SpiDataAddr && spiStart >= 0 && edgeCnt > spiStart + 2 * spiLen) begin
            rxRead = 1'b1;
        end
        req      = '0;
        req.re   = 1'b1;
        req.addr = addr[31:2];
        @(posedge clk);
        #1;
        req = '0;
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic drainReads();
        for (int n = 0; expData.size() != 0; n++) begin
            if (n == 4) begin
                timeoutFail("outstanding read responses");
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic waitSpiIdle();
        for (int n = 0; spiCs !== 1'b1; n++) begin
            if (n == 100) begin
                timeoutFail("SPI chip select to rise");
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        drainReads();
        $display("[%s] %0d errors", name, errors - errBefore);
    endtask

    // Responses are stable by the falling edge.
    always @(negedge clk) begin
        if (!rst && rsp.rvalid) begin
            if (expData.size() == 0) begin
                $display("Read response arrived with no read outstanding");
                errors++;
            end else begin
                cmpExp  = expData.pop_front();
                cmpAddr = expAddr.pop_front();
                checks++;
                if (rsp.rdata !== cmpExp) begin
                    $display("Mismatch rsp_o.rdata at %h: expected %h, got %h",
                             cmpAddr, cmpExp, rsp.rdata);
                    errors++;
                end
            end
        end
    end

    task automatic byteMaskTest();
        int          errBefore;
        logic [31:0] addr;
        logic [31:0] r;
        errBefore = errors;
        for (int i = 0; i < 12; i++) begin
            r = nextRand();
            addr = r[4] ? MtimecmpAddr + 32'd4 : MtimecmpAddr;
            busWrite(addr, nextRand(), r[3:0]);
            busRead(addr);
        end
        busRead(MtimecmpAddr);
        busRead(MtimecmpAddr + 32'd4);
        busRead(32'hFF00_0008);
        busRead(32'hFF00_0020);
        busRead(32'h0000_1000);
        reportTest("byte-masked writes", errBefore);
    endtask

    task automatic timerTest();
        int          errBefore;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [63:0] target;
        errBefore = errors;
        hi = nextRand() & 32'h0000_FFFF;
        lo = nextRand() & 32'h7FFF_FFFF;
        busWrite(MtimecmpAddr + 32'd4, 32'hFFFF_FFFF, 4'hF);
        busWrite(MtimeAddr + 32'd4, hi, 4'hF);
        busWrite(MtimeAddr, lo, 4'hF);
        for (int i = 0; i < 6; i++) begin
            busRead(MtimeAddr);
            idleCycles(i);
        end
        busRead(MtimeAddr + 32'd4);
        checks++;
        if (mtime !== mtimeAt(edgeCnt)) begin
            $display("Mismatch mtime_o: expected %h, got %h", mtimeAt(edgeCnt), mtime);
            errors++;
        end
        // Forty steps ahead, far enough to be reached only after the writes.
        target = mtimeBase + 64'(40 * TimerStep);
        busWrite(MtimecmpAddr, target[31:0], 4'hF);
        busWrite(MtimecmpAddr + 32'd4, target[63:32], 4'hF);
        checkBit("timerIrq_o", timerIrq, 1'b0);
        for (int n = 0; timerIrq !== 1'b1; n++) begin
            if (n == 400) begin
                timeoutFail("timer interrupt");
            end
            @(posedge clk);
            #1;
        end
        checks++;
        if (mtime !== target) begin
            $display("Mismatch mtime_o: expected %h, got %h", target, mtime);
            errors++;
        end
        reportTest("mtime counting", errBefore);
    endtask

    task automatic spiTransferTest();
        int          errBefore;
        int          len;
        logic [3:0]  mask;
        errBefore = errors;
        for (int k = 0; k < 3; k++) begin
            len  = (k == 0) ? 8 : (k == 1) ? 16 : 32;
            mask = (k == 0) ? 4'b0001 : (k == 1) ? 4'b0011 : 4'b1111;
            busWrite(SpiDataAddr, nextRand(), mask);
            // Status, cs and sck are checked through the whole busy window and one cycle past it.
            for (int i = 0; i < 2 * len + 2; i++) begin
                checkBit("spiCs_o", spiCs, !spiBusyAt(edgeCnt));
                checkBit("spiSck_o", spiSck, spiSckAt(edgeCnt));
                busRead(SpiStatusAddr);
            end
            waitSpiIdle();
            busRead(SpiDataAddr);
            busRead(SpiStatusAddr);
        end
        reportTest("SPI transfers", errBefore);
    endtask

    task automatic spiBusyTest();
        int          errBefore;
        logic [31:0] first;
        errBefore = errors;
        first = nextRand();
        busWrite(SpiDataAddr, first, 4'hF);
        idleCycles(3);
        busWrite(SpiDataAddr, ~first, 4'hF);
        busRead(SpiStatusAddr);
        waitSpiIdle();
        busRead(SpiDataAddr);
        busRead(SpiStatusAddr);
        reportTest("SPI write while busy", errBefore);
    endtask

    task automatic sysConTest();
        int          errBefore;
        logic [31:0] r;
        errBefore = errors;
        r = nextRand();
        busWrite(SysConAddr, {r[31:8], SysRebootCode}, 4'b0001);
        checkBit("reboot_o", reboot, 1'b1);
        checkBit("powerOff_o", powerOff, 1'b0);
        idleCycles(1);
        checkBit("reboot_o", reboot, 1'b0);
        busWrite(SysConAddr, {r[31:8], SysPowerOffCode}, 4'b0001);
        checkBit("powerOff_o", powerOff, 1'b1);
        checkBit("reboot_o", reboot, 1'b0);
        idleCycles(1);
        checkBit("powerOff_o", powerOff, 1'b0);
        // Neither a code outside lane 0 nor an unknown code may fire.
        busWrite(SysConAddr, {16'h0, SysRebootCode, SysRebootCode}, 4'b0010);
        checkBit("reboot_o", reboot, 1'b0);
        busWrite(SysConAddr, 32'h0000_0012, 4'b0001);
        checkBit("reboot_o", reboot, 1'b0);
        checkBit("powerOff_o", powerOff, 1'b0);
        idleCycles(1);
        checkBit("reboot_o", reboot, 1'b0);
        checkBit("powerOff_o", powerOff, 1'b0);
        busRead(SysConAddr);
        reportTest("SysCon commands", errBefore);
    endtask

    initial begin
        req       = '0;
        rst       = 1'b1;
        errors    = 0;
        checks    = 0;
        seed      = 32'h9fe61f32;
        cmpModel  = '0;
        mtimeBase = '0;
        mtimeEdge = 0;
        spiStart  = -1;
        spiLen    = 0;
        spiWord   = '0;
        rxRead    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        byteMaskTest();
        timerTest();
        spiTransferTest();
        spiBusyTest();
        sysConTest();
        finishRun();
    end

endmodule

//--- bench/ioSubsystem_chk.sv
`timescale 1ns/1ps

module ioSubsystem_chk (
    input logic               clk,
    input logic               rst,
    input periphPkg::busReq_t req_i,
    input periphPkg::busRsp_t rsp_i,
    input logic               spiCs_i,
    input logic               spiSck_i,
    input logic               reboot_i,
    input logic               powerOff_i
);
    int failCount = 0;

    // Every read answers in the next cycle, and nothing answers without a read.
    rspFollowsRead: assert property (@(posedge clk) disable iff (rst)
        req_i.re |=> rsp_i.rvalid)
        else begin
            $error("read response missing one cycle after re");
            failCount++;
        end

    noSpuriousRsp: assert property (@(posedge clk) disable iff (rst)
        !req_i.re |=> !rsp_i.rvalid)
        else begin
            $error("read response without a read request");
            failCount++;
        end

    rebootSingle: assert property (@(posedge clk) disable iff (rst)
        reboot_i |=> !reboot_i)
        else begin
            $error("reboot pulse longer than one cycle");
            failCount++;
        end

    powerOffSingle: assert property (@(posedge clk) disable iff (rst)
        powerOff_i |=> !powerOff_i)
        else begin
            $error("power-off pulse longer than one cycle");
            failCount++;
        end

    // sck may only move inside a transfer.
    sckInsideCs: assert property (@(posedge clk) disable iff (rst)
        !$stable(spiSck_i) |-> (!spiCs_i && !$past(spiCs_i)))
        else begin
            $error("sck toggled while cs was high");
            failCount++;
        end

endmodule

//--- hw/ioSubsystem.sv
`timescale 1ns/1ps

module ioSubsystem (
    input  logic               clk,
    input  logic               rst,
    input  periphPkg::busReq_t req_i,
    output periphPkg::busRsp_t rsp_o,
    input  logic               spiMiso_i,
    output logic               spiCs_o,
    output logic               spiSck_o,
    output logic               spiMosi_o,
    output logic [63:0]        mtime_o,
    output logic               timerIrq_o,
    output logic               reboot_o,
    output logic               powerOff_o
);
    import periphPkg::*;

    busReq_t timerReq;
    busReq_t spiReq;
    busReq_t sysReq;
    busRsp_t timerRsp;
    busRsp_t spiRsp;
    busRsp_t sysRsp;

    ioBusDecode decode (
        .clk        (clk),
        .rst        (rst),
        .req_i      (req_i),
        .timerReq_o (timerReq),
        .spiReq_o   (spiReq),
        .sysReq_o   (sysReq),
        .timerRsp_i (timerRsp),
        .spiRsp_i   (spiRsp),
        .sysRsp_i   (sysRsp),
        .rsp_o      (rsp_o)
    );

    machineTimer timer (
        .clk        (clk),
        .rst        (rst),
        .req_i      (timerReq),
        .rsp_o      (timerRsp),
        .mtime_o    (mtime_o),
        .timerIrq_o (timerIrq_o)
    );

    spiMaster spi (
        .clk       (clk),
        .rst       (rst),
        .req_i     (spiReq),
        .rsp_o     (spiRsp),
        .spiMiso_i (spiMiso_i),
        .spiCs_o   (spiCs_o),
        .spiSck_o  (spiSck_o),
        .spiMosi_o (spiMosi_o)
    );

    sysCtrl sysCon (
        .clk        (clk),
        .rst        (rst),
        .req_i      (sysReq),
        .rsp_o      (sysRsp),
        .reboot_o   (reboot_o),
        .powerOff_o (powerOff_o)
    );

endmodule

//--- hw/ioBusDecode.sv
`timescale 1ns/1ps

module ioBusDecode (
    input  logic               clk,
    input  logic               rst,
    input  periphPkg::busReq_t req_i,
    output periphPkg::busReq_t timerReq_o,
    output periphPkg::busReq_t spiReq_o,
    output periphPkg::busReq_t sysReq_o,
    input  periphPkg::busRsp_t timerRsp_i,
    input  periphPkg::busRsp_t spiRsp_i,
    input  periphPkg::busRsp_t sysRsp_i,
    output periphPkg::busRsp_t rsp_o
);
    import periphPkg::*;

    periphSel_e rdSel;
    periphSel_e wrSel;
    busRsp_t    noneRsp;

    function automatic periphSel_e classify(input logic [29:0] wordAddr);
        logic [31:0] byteAddr;
        periphSel_e  sel;
        byteAddr = {wordAddr, 2'b00};
        sel      = SelNone;
        if (byteAddr >= MtimeAddr && byteAddr <= MtimecmpAddr + 32'd4) begin
            sel = SelTimer;
        end else if (byteAddr == SpiDataAddr || byteAddr == SpiStatusAddr) begin
            sel = SelSpi;
        end else if (byteAddr == SysConAddr) begin
            sel = SelSysCon;
        end
        return sel;
    endfunction

    assign rdSel = req_i.re ? classify(req_i.addr) : SelNone;
    assign wrSel = req_i.we ? classify(req_i.addr) : SelNone;

    // Every peripheral sees the full request but only its own strobes.
    always_comb begin
        timerReq_o    = req_i;
        timerReq_o.re = (rdSel == SelTimer);
        timerReq_o.we = (wrSel == SelTimer);

        spiReq_o    = req_i;
        spiReq_o.re = (rdSel == SelSpi);
        spiReq_o.we = (wrSel == SelSpi);

        sysReq_o    = req_i;
        sysReq_o.re = (rdSel == SelSysCon);
        sysReq_o.we = (wrSel == SelSysCon);
    end

    // Unmapped reads still answer, with zero data.
    always_ff @(posedge clk) begin
        if (rst) begin
            noneRsp <= '0;
        end else begin
            noneRsp.rvalid <= req_i.re && (rdSel == SelNone);
            noneRsp.rdata  <= '0;
        end
    end

    // At most one source is valid per cycle and idle sources drive zero.
    assign rsp_o = timerRsp_i | spiRsp_i | sysRsp_i | noneRsp;

endmodule

//--- hw/sysCtrl.sv
`timescale 1ns/1ps

module sysCtrl (
    input  logic               clk,
    input  logic               rst,
    input  periphPkg::busReq_t req_i,
    output periphPkg::busRsp_t rsp_o,
    output logic               reboot_o,
    output logic               powerOff_o
);
    import periphPkg::*;

    logic cmdWrite;

    // The command byte lives in lane 0 only.
    assign cmdWrite = req_i.we && req_i.wmask[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            reboot_o   <= 1'b0;
            powerOff_o <= 1'b0;
            rsp_o      <= '0;
        end else begin
            reboot_o     <= cmdWrite && (req_i.wdata[7:0] == SysRebootCode);
            powerOff_o   <= cmdWrite && (req_i.wdata[7:0] == SysPowerOffCode);
            rsp_o.rvalid <= req_i.re;
            rsp_o.rdata  <= '0;
        end
    end

endmodule

//--- hw/spiMaster.sv
`timescale 1ns/1ps

module spiMaster (
    input  logic               clk,
    input  logic               rst,
    input  periphPkg::busReq_t req_i,
    output periphPkg::busRsp_t rsp_o,
    input  logic               spiMiso_i,
    output logic               spiCs_o,
    output logic               spiSck_o,
    output logic               spiMosi_o
);
    import periphPkg::*;

    spiState_e   state;
    logic [5:0]  bitCnt;
    logic [31:0] buffer;
    logic [31:0] rxData;
    logic        rxValid;
    logic        busy;
    logic        isStatus;
    logic        start;
    logic [31:0] loadWord;
    logic [5:0]  loadLen;
    logic [31:0] statusWord;
    logic [31:0] rdWord;

    assign busy     = (state != SpiIdle);
    assign isStatus = (req_i.addr[0] == SpiStatusAddr[2]);
    // Data writes while a transfer runs are dropped.
    assign start    = req_i.we && !isStatus && !busy;

    // The payload is left-aligned so the MSB always leaves first.
    always_comb begin
        case (req_i.wmask)
            4'b0001: begin
                loadWord = {req_i.wdata[7:0], 24'b0};
                loadLen  = 6'd8;
            end
            4'b0011: begin
                loadWord = {req_i.wdata[15:0], 16'b0};
                loadLen  = 6'd16;
            end
            default: begin
                loadWord = req_i.wdata;
                loadLen  = 6'd32;
            end
        endcase
    end

    always_comb begin
        statusWord                      = '0;
        statusWord[SpiStatusBusyBit]    = busy;
        statusWord[SpiStatusRxValidBit] = rxValid;
        rdWord = isStatus ? statusWord : rxData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SpiIdle;
            bitCnt    <= '0;
            rxValid   <= 1'b0;
            spiCs_o   <= 1'b1;
            spiSck_o  <= 1'b0;
            spiMosi_o <= 1'b0;
            rsp_o     <= '0;
        end else begin
            rsp_o.rvalid <= req_i.re;
            rsp_o.rdata  <= req_i.re ? rdWord : '0;
            if (req_i.re && !isStatus) begin
                rxValid <= 1'b0;
            end

            case (state)
                SpiIdle: begin
                    if (start) begin
                        state     <= SpiLow;
                        bitCnt    <= loadLen;
                        spiCs_o   <= 1'b0;
                        spiSck_o  <= 1'b0;
                        spiMosi_o <= loadWord[31];
                    end
                end
                SpiLow: begin
                    if (bitCnt != '0) begin
                        state    <= SpiHigh;
                        spiSck_o <= 1'b1;
                        bitCnt   <= bitCnt - 1'b1;
                    end else begin
                        // Trailing cycle with sck low before cs is released.
                        state   <= SpiIdle;
                        spiCs_o <= 1'b1;
                        rxValid <= 1'b1;
                    end
                end
                SpiHigh: begin
                    state     <= SpiLow;
                    spiSck_o  <= 1'b0;
                    spiMosi_o <= buffer[31];
                end
                default: state <= SpiIdle;
            endcase
        end
    end

    // MISO shifts in at the edge that raises sck; after N shifts the received
    // bits sit right-aligned.
    always_ff @(posedge clk) begin
        if (state == SpiIdle && start) begin
            buffer <= loadWord;
        end else if (state == SpiLow && bitCnt != '0) begin
            buffer <= {buffer[30:0], spiMiso_i};
        end
        if (state == SpiLow && bitCnt == '0) begin
            rxData <= buffer;
        end
    end

endmodule

//--- hw/machineTimer.sv
`timescale 1ns/1ps

module machineTimer (
    input  logic               clk,
    input  logic               rst,
    input  periphPkg::busReq_t req_i,
    output periphPkg::busRsp_t rsp_o,
    output logic [63:0]        mtime_o,
    output logic               timerIrq_o
);
    import periphPkg::*;

    logic [TimerDivWidth-1:0] divCnt;
    logic                     tick;
    logic [63:0]              mtime;
    logic [63:0]              mtimecmp;
    logic [63:0]              mtimeStep;
    logic [63:0]              mtimeNext;
    logic [63:0]              mtimecmpNext;
    logic [3:0]               byteOff;
    logic [31:0]              rdWord;

    function automatic logic [31:0] mergeBytes(
        input logic [31:0] old,
        input logic [31:0] data,
        input logic [3:0]  mask
    );
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign tick    = (divCnt == '0);
    assign byteOff = {req_i.addr[1:0], 2'b00};
    assign mtime_o = mtime;

    // Written bytes replace the stepped value, unwritten bytes keep counting.
    always_comb begin
        mtimeStep    = tick ? mtime + 64'(TimerStep) : mtime;
        mtimeNext    = mtimeStep;
        mtimecmpNext = mtimecmp;
        if (req_i.we) begin
            case (byteOff)
                MtimeAddr[3:0]: begin
                    mtimeNext[31:0] = mergeBytes(mtimeStep[31:0], req_i.wdata, req_i.wmask);
                end
                MtimeAddr[3:0] + 4'd4: begin
                    mtimeNext[63:32] = mergeBytes(mtimeStep[63:32], req_i.wdata, req_i.wmask);
                end
                MtimecmpAddr[3:0]: begin
                    mtimecmpNext[31:0] = mergeBytes(mtimecmp[31:0], req_i.wdata, req_i.wmask);
                end
                MtimecmpAddr[3:0] + 4'd4: begin
                    mtimecmpNext[63:32] = mergeBytes(mtimecmp[63:32], req_i.wdata, req_i.wmask);
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (byteOff)
            MtimeAddr[3:0]:           rdWord = mtime[31:0];
            MtimeAddr[3:0] + 4'd4:    rdWord = mtime[63:32];
            MtimecmpAddr[3:0]:        rdWord = mtimecmp[31:0];
            MtimecmpAddr[3:0] + 4'd4: rdWord = mtimecmp[63:32];
            default:                  rdWord = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            divCnt     <= TimerDivWidth'(TimerDivide - 1);
            mtime      <= '0;
            mtimecmp   <= '0;
            timerIrq_o <= 1'b0;
            rsp_o      <= '0;
        end else begin
            divCnt       <= tick ? TimerDivWidth'(TimerDivide - 1) : divCnt - 1'b1;
            mtime        <= mtimeNext;
            mtimecmp     <= mtimecmpNext;
            timerIrq_o   <= (mtime >= mtimecmp);
            rsp_o.rvalid <= req_i.re;
            rsp_o.rdata  <= req_i.re ? rdWord : '0;
        end
    end

endmodule

//--- hw/periphPkg.sv
package periphPkg;

    // One request per cycle. re and we are single-cycle strobes on a shared address.
    typedef struct packed {
        logic        re;
        logic        we;
        logic [29:0] addr;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } busReq_t;

    // rdata is zero whenever rvalid is low, so responses can be ORed together.
    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
    } busRsp_t;

    typedef enum logic [1:0] {
        SelNone,
        SelTimer,
        SelSpi,
        SelSysCon
    } periphSel_e;

    typedef enum logic [1:0] {
        SpiIdle,
        SpiLow,
        SpiHigh
    } spiState_e;

    localparam logic [31:0] SpiDataAddr   = 32'hFF00_0000;
    localparam logic [31:0] SpiStatusAddr = 32'hFF00_0004;
    localparam logic [31:0] SysConAddr    = 32'hFF00_0010;
    localparam logic [31:0] MtimeAddr     = 32'hFF00_0100;
    localparam logic [31:0] MtimecmpAddr  = 32'hFF00_0108;

    localparam int TimerDivide   = 5;
    localparam int TimerDivWidth = $clog2(TimerDivide);
    localparam int TimerStep     = 3;

    localparam logic [7:0] SysRebootCode   = 8'h77;
    localparam logic [7:0] SysPowerOffCode = 8'h55;

    localparam int SpiStatusBusyBit    = 0;
    localparam int SpiStatusRxValidBit = 8;

endpackage
